/* rv_isa_pkg.sv */
// RV32I encodings for the kept subset only: integer ALU ops, lw and sw
// No branch, jump, CSR or sub-word memory encodings live here
`default_nettype none

package rv_isa_pkg;

    // ========================================
    // Major opcodes
    // ========================================
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;

    // funct3 values
    localparam logic [2:0] f3_add  = 3'b000;  // Also sub, selected by bit 30
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;  // srl or sra by bit 30
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_word = 3'b010;  // lw and sw width

    // ALU operations, alu_none makes the ALU output zero
    typedef enum logic [3:0] {
        alu_none = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_sra  = 4'd6,
        alu_srl  = 4'd7,
        alu_slt  = 4'd8,
        alu_add  = 4'd9
    } alu_op_t;

    localparam logic [31:0] nop_instr = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire

/* pipe_pkg.sv */
// Datapath widths and the EX operand source select
// Memory addresses are word addresses, byte address bits 31 to 2
`default_nettype none

package pipe_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-3:0] mem_addr_t;

    // ========================================
    // Forwarding select for the EX operands
    // ========================================
    typedef enum logic [1:0] {
        fwd_reg = 2'b00,  // Value read from the register file in ID
        fwd_mem = 2'b01,  // ALU result sitting in MEM
        fwd_wb  = 2'b10   // Write-back value
    } fwd_sel_t;

endpackage

`default_nettype wire

/* pipe_control.sv */
// Decode in ID, control bits carried through EX, MEM and WB
// Load-use on rs1, or on rs2 for R-type and sw, costs one bubble
// Opcodes outside the kept subset decode as a bubble
`timescale 1ns/1ps
`default_nettype none

module pipe_control (
    input  logic                clk,
    input  logic                rst_n,
    input  pipe_pkg::word_t     instr,
    output logic                hold,
    output pipe_pkg::reg_addr_t rs1,
    output pipe_pkg::reg_addr_t rs2,
    output rv_isa_pkg::alu_op_t alu_op,
    output logic                alu_src,
    output pipe_pkg::word_t     imm,
    output pipe_pkg::fwd_sel_t  fwd_a,
    output pipe_pkg::fwd_sel_t  fwd_b,
    output logic                mem_read,
    output logic                mem_write,
    output logic                wb_from_mem,
    output logic                wb_we,
    output pipe_pkg::reg_addr_t wb_rd
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic       is_op, is_op_imm, is_load, is_store;
    logic       reg_we, uses_rs2;

    logic       ex_we, ex_load, ex_store;
    reg_addr_t  ex_rd, ex_rs1, ex_rs2;
    logic       mem_we;
    reg_addr_t  mem_rd;

    // MEM beats WB, x0 never forwards
    function automatic fwd_sel_t pick_src(input reg_addr_t src,
                                          input logic m_we, input reg_addr_t m_rd,
                                          input logic w_we, input reg_addr_t w_rd);
        if (m_we && m_rd != '0 && m_rd == src)
            return fwd_mem;
        else if (w_we && w_rd != '0 && w_rd == src)
            return fwd_wb;
        return fwd_reg;
    endfunction

    // ========================================
    // ID decode
    // ========================================
    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign rd        = instr[11:7];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign is_op     = (opcode == opcode_op);
    assign is_op_imm = (opcode == opcode_op_imm);
    assign is_load   = (opcode == opcode_load);
    assign is_store  = (opcode == opcode_store);
    assign reg_we    = is_op | is_op_imm | is_load;
    assign uses_rs2  = is_op | is_store;
    assign alu_src   = is_op_imm | is_load | is_store;

    always_comb begin
        alu_op = alu_none;
        if (is_op || is_op_imm) begin
            case (funct3)
                f3_add:  alu_op = (is_op && instr[30]) ? alu_sub : alu_add;
                f3_sll:  alu_op = alu_sll;
                f3_slt:  alu_op = alu_slt;
                f3_xor:  alu_op = alu_xor;
                f3_sr:   alu_op = instr[30] ? alu_sra : alu_srl;
                f3_or:   alu_op = alu_or;
                f3_and:  alu_op = alu_and;
                default: alu_op = alu_none;
            endcase
        end else if ((is_load || is_store) && funct3 == f3_word) begin
            alu_op = alu_add;  // Address calculation
        end
    end

    always_comb begin
        if (is_store)
            imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        else if (is_op_imm && (funct3 == f3_sll || funct3 == f3_sr))
            imm = {27'b0, instr[24:20]};  // Shift amount
        else
            imm = {{20{instr[31]}}, instr[31:20]};
    end

    // Load in EX feeding the ID instruction
    assign hold = ex_load && ex_rd != '0 &&
                  (ex_rd == rs1 || (uses_rs2 && ex_rd == rs2));

    assign fwd_a = pick_src(ex_rs1, mem_we, mem_rd, wb_we, wb_rd);
    assign fwd_b = pick_src(ex_rs2, mem_we, mem_rd, wb_we, wb_rd);

    // ========================================
    // Control pipeline
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_we       <= 1'b0;
            ex_load     <= 1'b0;
            ex_store    <= 1'b0;
            ex_rd       <= '0;
            ex_rs1      <= '0;
            ex_rs2      <= '0;
            mem_we      <= 1'b0;
            mem_read    <= 1'b0;
            mem_write   <= 1'b0;
            mem_rd      <= '0;
            wb_we       <= 1'b0;
            wb_from_mem <= 1'b0;
            wb_rd       <= '0;
        end else begin
            ex_we       <= reg_we & ~hold;   // Bubble on load-use
            ex_load     <= is_load & ~hold;
            ex_store    <= is_store & ~hold;
            ex_rd       <= rd;
            ex_rs1      <= rs1;
            ex_rs2      <= rs2;
            mem_we      <= ex_we;
            mem_read    <= ex_load;
            mem_write   <= ex_store;
            mem_rd      <= ex_rd;
            wb_we       <= mem_we;
            wb_from_mem <= mem_read;
            wb_rd       <= mem_rd;
        end
    end

endmodule

`default_nettype wire

/* fetch_stage.sv */
// PC and IF/ID instruction register
// No redirect path, the PC only counts up or holds
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hold,
    input  pipe_pkg::word_t     imem_rdata,
    output pipe_pkg::mem_addr_t imem_addr,
    output pipe_pkg::word_t     instr
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    word_t pc;

    assign imem_addr = pc[xlen-1:2];  // Word address of the PC

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc    <= '0;
            instr <= nop_instr;
        end else if (!hold) begin
            pc    <= pc + 32'd4;
            instr <= imem_rdata;
        end
    end

endmodule

`default_nettype wire

/* reg_file.sv */
// 32 x 32 register file, two combinational reads, one write at the WB edge
// Reads see the word being written in the same cycle
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  pipe_pkg::reg_addr_t rs1,
    input  pipe_pkg::reg_addr_t rs2,
    output pipe_pkg::word_t     rs1_data,
    output pipe_pkg::word_t     rs2_data,
    input  logic                wb_we,
    input  pipe_pkg::reg_addr_t wb_rd,
    input  pipe_pkg::word_t     wb_data
);
    import pipe_pkg::*;

    word_t regs [32];
    logic  wr_en;

    assign wr_en = wb_we && wb_rd != '0;  // x0 stays zero

    // Write-through on a same-cycle hit
    assign rs1_data = (wr_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (wr_en && wb_rd == rs2) ? wb_data : regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

`default_nettype wire

/* execute_stage.sv */
// ID/EX operand registers, forwarding muxes, ALU and EX/MEM registers
// Shifts use the low five bits of the second operand
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  pipe_pkg::word_t     rs1_data,
    input  pipe_pkg::word_t     rs2_data,
    input  pipe_pkg::word_t     imm,
    input  pipe_pkg::word_t     wb_data,
    input  rv_isa_pkg::alu_op_t alu_op,
    input  logic                alu_src,
    input  logic                hold,
    input  pipe_pkg::fwd_sel_t  fwd_a,
    input  pipe_pkg::fwd_sel_t  fwd_b,
    output pipe_pkg::word_t     mem_result,
    output pipe_pkg::word_t     mem_store_data
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    word_t   ex_rs1_data, ex_rs2_data, ex_imm;
    alu_op_t ex_op;
    logic    ex_src;
    word_t   opnd_a, fwd_b_val, opnd_b;
    word_t   alu_out;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // ========================================
    // ID/EX
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_op  <= alu_none;
            ex_src <= 1'b0;
        end else begin
            ex_op  <= hold ? alu_none : alu_op;  // Bubble
            ex_src <= hold ? 1'b0 : alu_src;
        end
    end

    always_ff @(posedge clk) begin
        ex_rs1_data <= rs1_data;
        ex_rs2_data <= rs2_data;
        ex_imm      <= imm;
    end

    assign opnd_a    = fwd_mux(fwd_a, ex_rs1_data, mem_result, wb_data);
    assign fwd_b_val = fwd_mux(fwd_b, ex_rs2_data, mem_result, wb_data);
    assign opnd_b    = ex_src ? ex_imm : fwd_b_val;  // Immediate wins over forwarding

    always_comb begin
        case (ex_op)
            alu_add: alu_out = opnd_a + opnd_b;
            alu_sub: alu_out = opnd_a - opnd_b;
            alu_and: alu_out = opnd_a & opnd_b;
            alu_or:  alu_out = opnd_a | opnd_b;
            alu_xor: alu_out = opnd_a ^ opnd_b;
            alu_sll: alu_out = opnd_a << opnd_b[4:0];
            alu_srl: alu_out = opnd_a >> opnd_b[4:0];
            alu_sra: alu_out = word_t'($signed(opnd_a) >>> opnd_b[4:0]);
            alu_slt: alu_out = {31'b0, $signed(opnd_a) < $signed(opnd_b)};
            default: alu_out = '0;
        endcase
    end

    // EX/MEM, store data is the forwarded rs2
    always_ff @(posedge clk) begin
        mem_result     <= alu_out;
        mem_store_data <= fwd_b_val;
    end

endmodule

`default_nettype wire

/* mem_wb_stage.sv */
// Data memory drive from MEM, MEM/WB registers and write-back select
// dmem_rdata must be valid in the same cycle as dmem_ren
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  pipe_pkg::word_t     mem_result,
    input  pipe_pkg::word_t     mem_store_data,
    input  logic                mem_read,
    input  logic                mem_write,
    input  logic                wb_from_mem,
    input  pipe_pkg::word_t     dmem_rdata,
    output logic                dmem_ren,
    output logic                dmem_wen,
    output pipe_pkg::mem_addr_t dmem_addr,
    output pipe_pkg::word_t     dmem_wdata,
    output pipe_pkg::word_t     wb_data
);
    import pipe_pkg::*;

    word_t wb_result, wb_load;

    assign dmem_ren   = mem_read;
    assign dmem_wen   = mem_write;
    assign dmem_addr  = mem_result[xlen-1:2];  // Word aligned access only
    assign dmem_wdata = mem_store_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_result <= '0;
            wb_load   <= '0;
        end else begin
            wb_result <= mem_result;
            if (mem_read)
                wb_load <= dmem_rdata;  // Only sample a real read
        end
    end

    assign wb_data = wb_from_mem ? wb_load : wb_result;

endmodule

`default_nettype wire

/* rv_pipeline.sv */
// Five-stage in-order RV32I pipeline, ALU ops plus lw and sw only
// Both memories must answer combinationally in the same cycle
// No branches, no cache stalls, memory words in native order
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline (
    input  logic               clk,
    input  logic               rst_n,
    output pipe_pkg::mem_addr_t imem_addr,
    input  pipe_pkg::word_t     imem_rdata,
    output logic               dmem_ren,
    output logic               dmem_wen,
    output pipe_pkg::mem_addr_t dmem_addr,
    output pipe_pkg::word_t     dmem_wdata,
    input  pipe_pkg::word_t     dmem_rdata
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    word_t     instr;
    logic      hold;
    reg_addr_t rs1, rs2;
    word_t     rs1_data, rs2_data;
    alu_op_t   alu_op;
    logic      alu_src;
    word_t     imm;
    fwd_sel_t  fwd_a, fwd_b;
    word_t     mem_result, mem_store_data;
    logic      mem_read, mem_write, wb_from_mem;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    pipe_control i_pipe_control (
        .clk, .rst_n, .instr, .hold, .rs1, .rs2,
        .alu_op, .alu_src, .imm, .fwd_a, .fwd_b,
        .mem_read, .mem_write, .wb_from_mem, .wb_we, .wb_rd
    );

    fetch_stage i_fetch_stage (
        .clk, .rst_n, .hold, .imem_rdata, .imem_addr, .instr
    );

    reg_file i_reg_file (
        .clk, .rst_n, .rs1, .rs2, .rs1_data, .rs2_data, .wb_we, .wb_rd, .wb_data
    );

    execute_stage i_execute_stage (
        .clk, .rst_n, .rs1_data, .rs2_data, .imm, .wb_data, .alu_op, .alu_src,
        .hold, .fwd_a, .fwd_b, .mem_result, .mem_store_data
    );

    mem_wb_stage i_mem_wb_stage (
        .clk, .rst_n, .mem_result, .mem_store_data, .mem_read, .mem_write,
        .wb_from_mem, .dmem_rdata, .dmem_ren, .dmem_wen, .dmem_addr, .dmem_wdata,
        .wb_data
    );

endmodule

`default_nettype wire

/* rv_pipeline_assertions.sv */
// Memory port checks, bound into every rv_pipeline instance
// Reset is synchronous, so the fetch check starts two edges after rst_n rises
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline_assertions (
    input logic                clk,
    input logic                rst_n,
    input logic                dmem_ren,
    input logic                dmem_wen,
    input pipe_pkg::mem_addr_t imem_addr
);
    import pipe_pkg::*;

    // Load and store never share the MEM stage
    no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_ren && dmem_wen))
        else $error("dmem_ren and dmem_wen high in the same cycle");

    idle_after_reset: assert property (@(posedge clk)
        !rst_n |=> (!dmem_ren && !dmem_wen))
        else $error("Data memory strobe active in the cycle after reset");

    // No redirects, so fetch steps one word or stalls
    fetch_step: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (imem_addr == $past(imem_addr) ||
                          imem_addr == mem_addr_t'($past(imem_addr) + 1'b1)))
        else $error("imem_addr moved by something other than zero or one word");

endmodule

bind rv_pipeline rv_pipeline_assertions i_rv_pipeline_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .dmem_ren  (dmem_ren),
    .dmem_wen  (dmem_wen),
    .imem_addr (imem_addr)
);

`default_nettype wire

/* tb_rv_pipeline.sv */
// Testbench for rv_pipeline with program and expected stores taken from rv_vectors.txt
// Memories answer combinationally and refresh 2 ns after each rising edge
// Only 64 words of each memory are modeled and instruction reads beyond them return NOPs
// Stops at the first mismatch or when the cycle limit runs out
`timescale 1ns/1ps
`default_nettype none

module tb_rv_pipeline;
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int clk_period_ns  = 20;
    localparam int drive_delay_ns = 2;
    localparam int reset_cycles   = 2;
    localparam int timeout_margin = 20;
    localparam int mem_bits       = 6;
    localparam int mem_words      = 1 << mem_bits;

    logic      clk;
    logic      rst_n;
    mem_addr_t imem_addr, dmem_addr;
    word_t     imem_rdata, dmem_rdata, dmem_wdata;
    logic      dmem_ren, dmem_wen;

    word_t     imem [mem_words];
    word_t     dmem [mem_words];
    mem_addr_t exp_addr [$];
    word_t     exp_data [$];
    int        prog_len;
    int        cycle_count;
    int        cycle_limit;
    int        store_idx;

    rv_pipeline i_rv_pipeline (
        .clk, .rst_n, .imem_addr, .imem_rdata, .dmem_ren, .dmem_wen,
        .dmem_addr, .dmem_wdata, .dmem_rdata
    );

    // ========================================
    // Memory models
    // ========================================
    function automatic word_t fill_word(input mem_addr_t a);
        return {a, 2'b00} ^ 32'h5a5a_a5a5;  // Unwritten data words
    endfunction

    function automatic word_t read_imem(input mem_addr_t a);
        if (a < mem_addr_t'(mem_words))
            return imem[a[mem_bits-1:0]];
        return nop_instr;
    endfunction

    function automatic word_t read_dmem(input mem_addr_t a);
        if (a < mem_addr_t'(mem_words))
            return dmem[a[mem_bits-1:0]];
        return fill_word(a);
    endfunction

    initial begin
        clk = 1'b0;
        forever #(clk_period_ns / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        #(drive_delay_ns);
        imem_rdata = read_imem(imem_addr);
        dmem_rdata = dmem_ren ? read_dmem(dmem_addr) : 'x;  // Data only on a read
    end

    // ========================================
    // Checks
    // ========================================
    task automatic abort_run(input string why);
        $display("tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            abort_run("Stopping at first mismatch");
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            abort_run("Stopping at first mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            abort_run("Stopping at first mismatch");
        end
    endtask

    // Store completes at the coming rising edge
    task automatic record_store();
        check_addr("dmem_addr", dmem_addr, exp_addr[store_idx]);
        check_word("dmem_wdata", dmem_wdata, exp_data[store_idx]);
        if (dmem_addr < mem_addr_t'(mem_words))
            dmem[dmem_addr[mem_bits-1:0]] = dmem_wdata;
        store_idx++;
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        int    i;
        string line;
        byte   kind;
        word_t a, b;
        for (i = 0; i < mem_words; i++) begin
            imem[i[mem_bits-1:0]] = nop_instr;
            dmem[i[mem_bits-1:0]] = fill_word(mem_addr_t'(i));
        end
        prog_len = 0;
        fd = $fopen("rv_vectors.txt", "r");
        if (fd == 0)
            abort_run("Could not open rv_vectors.txt");
        while ($fgets(line, fd)) begin
            kind = line.getc(0);
            if (line.len() < 2 || kind == "#")
                continue;  // Blank or comment line
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
            case (kind)
                "P": begin
                    if (n < 1 || prog_len >= mem_words)
                        abort_run("Bad or too many P lines in rv_vectors.txt");
                    imem[prog_len[mem_bits-1:0]] = a;
                    prog_len++;
                end
                "D": begin
                    if (n != 2 || a >= mem_words)
                        abort_run("Bad D line in rv_vectors.txt");
                    dmem[a[mem_bits-1:0]] = b;
                end
                "E": begin
                    if (n != 2)
                        abort_run("Bad E line in rv_vectors.txt");
                    exp_addr.push_back(mem_addr_t'(a));
                    exp_data.push_back(b);
                end
                default: abort_run("Unknown line type in rv_vectors.txt");
            endcase
        end
        $fclose(fd);
        if (exp_addr.size() == 0)
            abort_run("No expected stores in rv_vectors.txt");
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        rst_n       = 1'b0;
        imem_rdata  = nop_instr;
        dmem_rdata  = '0;
        cycle_count = 0;
        store_idx   = 0;
        load_vectors();
        cycle_limit = 4 * prog_len + timeout_margin;

        repeat (reset_cycles) @(posedge clk);
        #(drive_delay_ns);
        rst_n = 1'b1;

        @(negedge clk);
        check_flag("dmem_ren", dmem_ren, 1'b0);  // Quiet right after reset
        check_flag("dmem_wen", dmem_wen, 1'b0);

        while (store_idx < exp_addr.size()) begin
            if (cycle_count >= cycle_limit)
                abort_run($sformatf("Timeout after %0d cycles, %0d of %0d stores seen",
                                    cycle_count, store_idx, exp_addr.size()));
            @(negedge clk);
            cycle_count++;
            if (dmem_wen)
                record_store();
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_vectors.txt */
# P <instr hex>, program words from word address 0
# D <word addr hex> <data hex> initial data, E <word addr hex> <data hex> expected stores in order
D 10 fffffff9
D 11 00000005
P 04002083 // lw   x1, 0x40(x0)
P 00308113 // addi x2, x1, 3     load-use on rs1
P 04402183 // lw   x3, 0x44(x0)
P 40310233 // sub  x4, x2, x3    load-use on rs2
P 003222b3 // slt  x5, x4, x3
P 40125313 // srai x6, x4, 1
P 01c25393 // srli x7, x4, 28
P 00419413 // slli x8, x3, 4
P 007344b3 // xor  x9, x6, x7
P 0084f533 // and  x10, x9, x8
P 005565b3 // or   x11, x10, x5
P fff5c613 // xori x12, x11, -1
P 0ff67693 // andi x13, x12, 0xff
P 1006e713 // ori  x14, x13, 0x100
P ff822793 // slti x15, x4, -8
P 00f70833 // add  x16, x14, x15
P 03042823 // sw   x16, 0x30(x8)
P 02642a23 // sw   x6, 0x34(x8)
P 00500013 // addi x0, x0, 5
P 02042e23 // sw   x0, 0x3c(x8)
P 02942c23 // sw   x9, 0x38(x8)
P 04442023 // sw   x4, 0x40(x8)
P 08002903 // lw   x18, 0x80(x0)
P 05242223 // sw   x18, 0x44(x8)  load-use on store data
E 20 000001af
E 21 fffffffb
E 23 00000000
E 22 fffffff4
E 24 fffffff7
E 25 000001af

/* all.f */
rv_isa_pkg.sv
pipe_pkg.sv
pipe_control.sv
fetch_stage.sv
reg_file.sv
execute_stage.sv
mem_wb_stage.sv
rv_pipeline.sv
rv_pipeline_assertions.sv
tb_rv_pipeline.sv

/* Makefile */
# Verilator flow for the RV32I pipeline testbench
# The run fails if the log holds the fail message or lacks the pass message

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_rv_pipeline
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := tests failed
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile rv_vectors.txt
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation PASSED"; \
	else echo "Simulation FAILED, no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
